// ==== hdl/core_pkg.sv ====
package core_pkg;

    localparam int XLEN = 32;

    // RV32I major opcodes
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt
    } alu_op_e;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instr;
    } if_id_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] rs1_val;
        logic [XLEN-1:0] rs2_val;
        logic [XLEN-1:0] imm;
        logic [4:0]      rd;
        alu_op_e         alu_op;
        logic            is_load;
        logic            is_store;
        logic            is_branch;
        logic            branch_ne;
        logic            is_jal;
        logic            use_imm;
        logic            reg_write;
    } id_ex_t;

    typedef struct packed {
        logic [XLEN-1:0] pc4;
        logic [XLEN-1:0] alu_result;
        logic [XLEN-1:0] store_data;
        logic [4:0]      rd;
        logic            is_load;
        logic            is_store;
        logic            is_jal;
        logic            reg_write;
    } ex_mem_t;

    typedef struct packed {
        logic [4:0]      rd;
        logic [XLEN-1:0] wdata;
        logic            reg_write;
    } mem_wb_t;

endpackage

// ==== hdl/pipe_stage_if.sv ====
`timescale 1ns/1ps

interface pipe_stage_if #(
    parameter type payload_t = logic
);

    payload_t d;
    payload_t q;
    logic     valid_q;
    logic     stall;
    logic     flush;

    // Upstream stage builds the next payload
    modport producer (
        output d
    );

    modport register (
        input  d,
        input  stall,
        input  flush,
        output q,
        output valid_q
    );

    modport consumer (
        input q,
        input valid_q
    );

endinterface

// ==== hdl/pipe_reg.sv ====
`timescale 1ns/1ps

module pipe_reg #(
    parameter type payload_t = logic
) (
    input logic             clk,
    input logic             rst,
    pipe_stage_if.register  stage
);

    payload_t q_r;
    logic     valid_r;

    // Flush beats stall, a flushed slot becomes a bubble
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_r <= 1'b0;
        end else if (stage.flush) begin
            valid_r <= 1'b0;
        end else if (!stage.stall) begin
            valid_r <= 1'b1;
        end
    end

    // Payload has no reset, valid bit qualifies it
    always_ff @(posedge clk) begin
        if (!stage.stall) begin
            q_r <= stage.d;
        end
    end

    assign stage.q       = q_r;
    assign stage.valid_q = valid_r;

endmodule

// ==== hdl/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      stall,
    input  logic                      redirect,
    input  logic [core_pkg::XLEN-1:0] redirect_target,
    output logic [core_pkg::XLEN-1:0] iad,
    input  logic [core_pkg::XLEN-1:0] idt,
    pipe_stage_if.producer            if_id
);

    logic [core_pkg::XLEN-1:0] pc;
    core_pkg::if_id_t          payload;

    // Redirect wins over a load-use hold
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_PC;
        end else if (redirect) begin
            pc <= redirect_target;
        end else if (!stall) begin
            pc <= pc + 32'd4;
        end
    end

    assign iad = pc;

    always_comb begin
        payload.pc    = pc;
        payload.instr = idt;
    end

    assign if_id.d = payload;

endmodule

// ==== hdl/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
    input  logic              clk,
    input  logic              rst,
    pipe_stage_if.consumer    if_id,
    pipe_stage_if.producer    id_ex,
    input  core_pkg::ex_mem_t ex_fwd,
    input  logic              ex_fwd_valid,
    input  core_pkg::mem_wb_t mem_fwd,
    input  logic              mem_fwd_valid,
    input  core_pkg::mem_wb_t wb,
    input  logic              wb_valid,
    output logic              stall
);

    logic [core_pkg::XLEN-1:0] regs [32];
    logic [core_pkg::XLEN-1:0] instr;
    logic [6:0]                opcode;
    logic [2:0]                funct3;
    logic [4:0]                rs1;
    logic [4:0]                rs2;
    logic                      uses_rs1;
    logic                      uses_rs2;
    logic                      wb_we;
    logic [core_pkg::XLEN-1:0] rf1;
    logic [core_pkg::XLEN-1:0] rf2;
    core_pkg::id_ex_t          dec;

    // Priority: execute result, then memory result, then register file
    function automatic logic [core_pkg::XLEN-1:0] pick(
        input logic [4:0]                rs,
        input logic [core_pkg::XLEN-1:0] rf_val,
        input core_pkg::ex_mem_t         ex,
        input logic                      ex_ok,
        input core_pkg::mem_wb_t         mem,
        input logic                      mem_ok
    );
        logic [core_pkg::XLEN-1:0] val;
        if (rs == 5'd0) begin
            val = '0;
        end else if (ex_ok && ex.reg_write && !ex.is_load && ex.rd == rs) begin
            val = ex.alu_result;
        end else if (mem_ok && mem.reg_write && mem.rd == rs) begin
            val = mem.wdata;
        end else begin
            val = rf_val;
        end
        return val;
    endfunction

    assign instr  = if_id.q.instr;
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    // Register file, x0 never written
    assign wb_we = wb_valid && wb.reg_write && (wb.rd != 5'd0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we) begin
            regs[wb.rd] <= wb.wdata;
        end
    end

    // Write-first read
    assign rf1 = (wb_we && wb.rd == rs1) ? wb.wdata : regs[rs1];
    assign rf2 = (wb_we && wb.rd == rs2) ? wb.wdata : regs[rs2];

    always_comb begin
        dec         = '0;
        dec.pc      = if_id.q.pc;
        dec.rd      = instr[11:7];
        dec.alu_op  = core_pkg::alu_add;
        dec.rs1_val = pick(rs1, rf1, ex_fwd, ex_fwd_valid, mem_fwd, mem_fwd_valid);
        dec.rs2_val = pick(rs2, rf2, ex_fwd, ex_fwd_valid, mem_fwd, mem_fwd_valid);
        uses_rs1    = 1'b0;
        uses_rs2    = 1'b0;
        case (opcode)
            core_pkg::op_reg: begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                dec.reg_write = 1'b1;
                case (funct3)
                    3'b000:  dec.alu_op = instr[30] ? core_pkg::alu_sub : core_pkg::alu_add;
                    3'b010:  dec.alu_op = core_pkg::alu_slt;
                    3'b100:  dec.alu_op = core_pkg::alu_xor;
                    3'b110:  dec.alu_op = core_pkg::alu_or;
                    3'b111:  dec.alu_op = core_pkg::alu_and;
                    default: dec.reg_write = 1'b0;
                endcase
            end
            core_pkg::op_imm: begin
                uses_rs1      = 1'b1;
                dec.use_imm   = 1'b1;
                dec.reg_write = (funct3 == 3'b000);
                dec.imm       = {{20{instr[31]}}, instr[31:20]};
            end
            core_pkg::op_load: begin
                uses_rs1      = 1'b1;
                dec.use_imm   = 1'b1;
                dec.is_load   = 1'b1;
                dec.reg_write = 1'b1;
                dec.imm       = {{20{instr[31]}}, instr[31:20]};
            end
            core_pkg::op_store: begin
                uses_rs1     = 1'b1;
                uses_rs2     = 1'b1;
                dec.use_imm  = 1'b1;
                dec.is_store = 1'b1;
                dec.imm      = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            core_pkg::op_branch: begin
                uses_rs1      = 1'b1;
                uses_rs2      = 1'b1;
                dec.is_branch = 1'b1;
                dec.branch_ne = funct3[0];
                dec.imm       = {{19{instr[31]}}, instr[31], instr[7],
                                 instr[30:25], instr[11:8], 1'b0};
            end
            core_pkg::op_jal: begin
                dec.is_jal    = 1'b1;
                dec.reg_write = 1'b1;
                dec.imm       = {{11{instr[31]}}, instr[31], instr[19:12],
                                 instr[20], instr[30:21], 1'b0};
            end
            default: begin
                dec.reg_write = 1'b0;
            end
        endcase
        // Writes to x0 are dropped here
        if (dec.rd == 5'd0) begin
            dec.reg_write = 1'b0;
        end
        // A bubble in IF/ID decodes to a no-op
        if (!if_id.valid_q) begin
            dec.is_load   = 1'b0;
            dec.is_store  = 1'b0;
            dec.is_branch = 1'b0;
            dec.is_jal    = 1'b0;
            dec.reg_write = 1'b0;
        end
    end

    // Load in execute feeding this instruction
    assign stall = if_id.valid_q && ex_fwd_valid && ex_fwd.is_load && ex_fwd.reg_write
                   && ((uses_rs1 && rs1 == ex_fwd.rd) || (uses_rs2 && rs2 == ex_fwd.rd));

    assign id_ex.d = dec;

endmodule

// ==== hdl/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
    pipe_stage_if.consumer            id_ex,
    pipe_stage_if.producer            ex_mem,
    output core_pkg::ex_mem_t         ex_result,
    output logic                      redirect,
    output logic [core_pkg::XLEN-1:0] redirect_target
);

    logic [core_pkg::XLEN-1:0] op_a;
    logic [core_pkg::XLEN-1:0] op_b;
    logic [core_pkg::XLEN-1:0] alu_out;
    logic [core_pkg::XLEN-1:0] pc4;
    logic                      valid;
    logic                      taken;

    assign valid = id_ex.valid_q;
    assign op_a  = id_ex.q.rs1_val;
    assign op_b  = id_ex.q.use_imm ? id_ex.q.imm : id_ex.q.rs2_val;
    assign pc4   = id_ex.q.pc + 32'd4;

    always_comb begin
        case (id_ex.q.alu_op)
            core_pkg::alu_add: alu_out = op_a + op_b;
            core_pkg::alu_sub: alu_out = op_a - op_b;
            core_pkg::alu_and: alu_out = op_a & op_b;
            core_pkg::alu_or:  alu_out = op_a | op_b;
            core_pkg::alu_xor: alu_out = op_a ^ op_b;
            core_pkg::alu_slt: alu_out = {31'd0, $signed(op_a) < $signed(op_b)};
            default:           alu_out = '0;
        endcase
    end

    // BEQ on equal, BNE on not equal
    assign taken = id_ex.q.is_branch
                   && ((id_ex.q.rs1_val == id_ex.q.rs2_val) ^ id_ex.q.branch_ne);

    assign redirect        = valid && (taken || id_ex.q.is_jal);
    assign redirect_target = id_ex.q.pc + id_ex.q.imm;

    // A bubble leaves with all side effects cleared
    always_comb begin
        ex_result.pc4        = pc4;
        ex_result.alu_result = id_ex.q.is_jal ? pc4 : alu_out;
        ex_result.store_data = id_ex.q.rs2_val;
        ex_result.rd         = id_ex.q.rd;
        ex_result.is_load    = valid && id_ex.q.is_load;
        ex_result.is_store   = valid && id_ex.q.is_store;
        ex_result.is_jal     = valid && id_ex.q.is_jal;
        ex_result.reg_write  = valid && id_ex.q.reg_write;
    end

    assign ex_mem.d = ex_result;

endmodule

// ==== hdl/memory_stage.sv ====
`timescale 1ns/1ps

module memory_stage (
    pipe_stage_if.consumer            ex_mem,
    pipe_stage_if.producer            mem_wb,
    output logic                      mreq,
    output logic                      write,
    output logic [core_pkg::XLEN-1:0] dad,
    output logic [core_pkg::XLEN-1:0] ddt_out,
    input  logic [core_pkg::XLEN-1:0] ddt_in
);

    logic              valid;
    core_pkg::mem_wb_t result;

    assign valid = ex_mem.valid_q;

    // Word access only, memory answers in this cycle
    assign mreq    = valid && (ex_mem.q.is_load || ex_mem.q.is_store);
    assign write   = valid && ex_mem.q.is_store;
    assign dad     = ex_mem.q.alu_result;
    assign ddt_out = ex_mem.q.store_data;

    // JAL link value already sits in alu_result
    always_comb begin
        result.rd        = ex_mem.q.rd;
        result.wdata     = ex_mem.q.is_load ? ddt_in : ex_mem.q.alu_result;
        result.reg_write = valid && ex_mem.q.reg_write;
    end

    assign mem_wb.d = result;

endmodule

// ==== hdl/rv_core_top.sv ====
`timescale 1ns/1ps

module rv_core_top #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        rst,
    output logic [31:0] iad,
    input  logic [31:0] idt,
    output logic [31:0] dad,
    output logic [31:0] ddt_out,
    input  logic [31:0] ddt_in,
    output logic        mreq,
    output logic        write
);

    logic                      stall;
    logic                      redirect;
    logic [core_pkg::XLEN-1:0] redirect_target;
    core_pkg::ex_mem_t         ex_result;

    pipe_stage_if #(.payload_t(core_pkg::if_id_t))  if_id ();
    pipe_stage_if #(.payload_t(core_pkg::id_ex_t))  id_ex ();
    pipe_stage_if #(.payload_t(core_pkg::ex_mem_t)) ex_mem ();
    pipe_stage_if #(.payload_t(core_pkg::mem_wb_t)) mem_wb ();

    // Redirect squashes the two younger slots, load-use inserts one bubble
    assign if_id.stall  = stall;
    assign if_id.flush  = redirect;
    assign id_ex.stall  = 1'b0;
    assign id_ex.flush  = redirect || stall;
    assign ex_mem.stall = 1'b0;
    assign ex_mem.flush = 1'b0;
    assign mem_wb.stall = 1'b0;
    assign mem_wb.flush = 1'b0;

    fetch_stage #(
        .RESET_PC(RESET_PC)
    ) u_fetch (
        .clk            (clk),
        .rst            (rst),
        .stall          (stall),
        .redirect       (redirect),
        .redirect_target(redirect_target),
        .iad            (iad),
        .idt            (idt),
        .if_id          (if_id.producer)
    );

    pipe_reg #(.payload_t(core_pkg::if_id_t)) u_if_id_reg (
        .clk  (clk),
        .rst  (rst),
        .stage(if_id.register)
    );

    decode_stage u_decode (
        .clk          (clk),
        .rst          (rst),
        .if_id        (if_id.consumer),
        .id_ex        (id_ex.producer),
        .ex_fwd       (ex_result),
        .ex_fwd_valid (id_ex.valid_q),
        .mem_fwd      (mem_wb.d),
        .mem_fwd_valid(ex_mem.valid_q),
        .wb           (mem_wb.q),
        .wb_valid     (mem_wb.valid_q),
        .stall        (stall)
    );

    pipe_reg #(.payload_t(core_pkg::id_ex_t)) u_id_ex_reg (
        .clk  (clk),
        .rst  (rst),
        .stage(id_ex.register)
    );

    execute_stage u_execute (
        .id_ex          (id_ex.consumer),
        .ex_mem         (ex_mem.producer),
        .ex_result      (ex_result),
        .redirect       (redirect),
        .redirect_target(redirect_target)
    );

    pipe_reg #(.payload_t(core_pkg::ex_mem_t)) u_ex_mem_reg (
        .clk  (clk),
        .rst  (rst),
        .stage(ex_mem.register)
    );

    memory_stage u_memory (
        .ex_mem (ex_mem.consumer),
        .mem_wb (mem_wb.producer),
        .mreq   (mreq),
        .write  (write),
        .dad    (dad),
        .ddt_out(ddt_out),
        .ddt_in (ddt_in)
    );

    pipe_reg #(.payload_t(core_pkg::mem_wb_t)) u_mem_wb_reg (
        .clk  (clk),
        .rst  (rst),
        .stage(mem_wb.register)
    );

endmodule

// ==== verification/rv_core_checker.sv ====
`timescale 1ns/1ps

module rv_core_checker (
    input logic        clk,
    input logic        rst,
    input logic [31:0] iad,
    input logic [31:0] dad,
    input logic [31:0] ddt_out,
    input logic        mreq,
    input logic        write
);

    write_needs_mreq: assert property (@(posedge clk)
        write |-> mreq && !$isunknown({dad, ddt_out}))
        else $error("write without mreq or with unknown address or data");

    iad_known: assert property (@(posedge clk) !rst |-> !$isunknown(iad))
        else $error("fetch address unknown outside reset");

    // Valid bits are clear once the first reset edge has passed
    mreq_low_in_reset: assert property (@(posedge clk) rst && $past(rst) |-> !mreq)
        else $error("mreq high while reset is held");

    iad_aligned: assert property (@(posedge clk) !rst |-> iad[1:0] == 2'b00)
        else $error("fetch address not word aligned");

endmodule

bind rv_core_top rv_core_checker i_checker (
    .clk    (clk),
    .rst    (rst),
    .iad    (iad),
    .dad    (dad),
    .ddt_out(ddt_out),
    .mreq   (mreq),
    .write  (write)
);

// ==== verification/rv_core_tb.sv ====
`timescale 1ns/1ps

module rv_core_tb;

    localparam logic [31:0] start_pc    = 32'h0000_0000;
    localparam logic [31:0] done_addr   = 32'h0000_03fc;
    localparam logic [31:0] poison_addr = 32'h0000_03f8;
    localparam int          num_tests   = 6;
    localparam int          cycle_limit = num_tests * 400;

    logic        clk;
    logic        rst;
    logic [31:0] iad;
    logic [31:0] idt;
    logic [31:0] dad;
    logic [31:0] ddt_out;
    logic [31:0] ddt_in;
    logic        mreq;
    logic        write;

    logic [31:0] imem [256];
    logic [31:0] dmem [256];
    logic [31:0] exp_addr [32];
    logic [31:0] exp_val [32];
    logic [4:0]  exp_count;
    logic [4:0]  exp_idx;
    logic [7:0]  pc_w;
    logic [31:0] r [16];
    logic [31:0] addr_v;
    logic [31:0] link;
    logic [31:0] acc;
    logic [31:0] rng = 32'hd68d_025b;
    string       test_name;
    int          test_errors = 0;
    int          pass_count = 0;
    int          fail_count = 0;
    int          cycles = 0;

    rv_core_top #(
        .RESET_PC(start_pc)
    ) i_rv_core_top (
        .clk    (clk),
        .rst    (rst),
        .iad    (iad),
        .idt    (idt),
        .dad    (dad),
        .ddt_out(ddt_out),
        .ddt_in (ddt_in),
        .mreq   (mreq),
        .write  (write)
    );

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return addr ^ 32'h6b1e_9c00;
    endfunction

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // RV32I encoders
    function automatic logic [31:0] alu_rr(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] addi(input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] lw(input logic [4:0] rd, input logic [4:0] rs1,
                                      input logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic logic [31:0] sw(input logic [4:0] rs2, input logic [4:0] rs1,
                                      input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] branch(input logic [2:0] f3, input logic [4:0] rs1,
                                          input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jal(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    task automatic emit(input logic [31:0] instr);
        imem[pc_w] = instr;
        pc_w       = pc_w + 8'd1;
    endtask

    task automatic expect_store(input logic [31:0] addr, input logic [31:0] val);
        exp_addr[exp_count] = addr;
        exp_val[exp_count]  = val;
        exp_count           = exp_count + 5'd1;
    endtask

    // x4 holds the poison value in the tests that use this
    task automatic poison_pair();
        emit(sw(5'd4, 5'd0, poison_addr[11:0]));
        emit(sw(5'd4, 5'd0, poison_addr[11:0]));
    endtask

    // Spare words are no-ops that carry their own address
    task automatic blank_program();
        for (int i = 0; i < 256; i++) begin
            imem[i[7:0]] = addi(5'd0, 5'd0, {2'b00, i[7:0], 2'b00});
        end
        pc_w      = 8'd0;
        exp_count = 5'd0;
    endtask

    task automatic start_test(input string name);
        @(negedge clk);
        rst         = 1'b1;
        test_name   = name;
        test_errors = 0;
        blank_program();
    endtask

    task automatic finish_test();
        emit(sw(5'd0, 5'd0, done_addr[11:0]));
        emit(jal(5'd0, 21'd0));
        repeat (4) @(negedge clk);
        rst = 1'b0;
        do begin
            @(negedge clk);
        end while (!(mreq && write && dad == done_addr));
        assert (exp_idx == exp_count) else begin
            $display("%s: only %0d of %0d expected stores reached memory",
                     test_name, exp_idx, exp_count);
            test_errors++;
        end
        if (test_errors == 0) begin
            pass_count++;
            $display("PASS %s", test_name);
        end else begin
            fail_count++;
            $display("FAIL %s with %0d errors", test_name, test_errors);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    assign idt    = imem[iad[9:2]];
    assign ddt_in = rst ? 32'd0 : dmem[dad[9:2]];

    // Fill during reset, store on the rising edge otherwise
    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 256; i++) begin
                dmem[i[7:0]] <= fill_word({22'd0, i[7:0], 2'b00});
            end
        end else if (mreq && write) begin
            dmem[dad[9:2]] <= ddt_out;
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            exp_idx <= 5'd0;
        end else if (mreq && write && dad != done_addr && dad != poison_addr) begin
            exp_idx <= exp_idx + 5'd1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles, %s never reached its done store",
                     cycles, test_name);
            $display("Simulation failed");
            $finish;
        end
    end

    store_check: assert property (@(posedge clk) disable iff (rst)
        (mreq && write && dad != done_addr && dad != poison_addr)
        |-> (exp_idx < exp_count && dad == exp_addr[exp_idx] && ddt_out == exp_val[exp_idx]))
    else begin
        $display("CHECK FAILED %s: expected %h at %h, actual %h at %h", test_name,
                 exp_val[$sampled(exp_idx)], exp_addr[$sampled(exp_idx)],
                 $sampled(ddt_out), $sampled(dad));
        test_errors++;
    end

    poison_check: assert property (@(posedge clk) disable iff (rst)
        !(mreq && write && dad == poison_addr))
    else begin
        $display("%s: a squashed store wrote the poison address", test_name);
        test_errors++;
    end

    reset_hold_check: assert property (@(posedge clk)
        rst && $past(rst) |-> !mreq && !write && iad == start_pc)
    else begin
        $display("%s: memory request or fetch address wrong during reset", test_name);
        test_errors++;
    end

    reset_release_check: assert property (@(posedge clk)
        $fell(rst) |-> !mreq && !write && iad == start_pc)
    else begin
        $display("%s: memory request or fetch address wrong after reset", test_name);
        test_errors++;
    end

    initial begin
        rst = 1'b1;
        blank_program();

        start_test("reset");
        finish_test();

        // Each ALU result feeds the next instruction directly
        start_test("alu_forwarding");
        r[1] = 32'd23;
        r[2] = 32'hffff_fff9;
        r[3] = r[1] + r[2];
        r[4] = r[3] - r[1];
        r[5] = r[4] & r[3];
        r[6] = r[5] | r[2];
        r[7] = r[6] ^ r[1];
        r[8] = ($signed(r[7]) < $signed(r[1])) ? 32'd1 : 32'd0;
        r[9] = r[8] + 32'd100;
        emit(addi(5'd1, 5'd0, 12'd23));
        emit(addi(5'd2, 5'd0, 12'hff9));
        emit(alu_rr(7'h00, 3'b000, 5'd3, 5'd1, 5'd2));
        emit(alu_rr(7'h20, 3'b000, 5'd4, 5'd3, 5'd1));
        emit(alu_rr(7'h00, 3'b111, 5'd5, 5'd4, 5'd3));
        emit(alu_rr(7'h00, 3'b110, 5'd6, 5'd5, 5'd2));
        emit(alu_rr(7'h00, 3'b100, 5'd7, 5'd6, 5'd1));
        emit(alu_rr(7'h00, 3'b010, 5'd8, 5'd7, 5'd1));
        emit(addi(5'd9, 5'd8, 12'd100));
        for (int k = 3; k <= 9; k++) begin
            addr_v = 32'h100 + k * 4;
            emit(sw(k[4:0], 5'd0, addr_v[11:0]));
            expect_store(addr_v, r[k[3:0]]);
        end
        finish_test();

        // Loaded register used by the very next instruction
        start_test("load_use");
        emit(addi(5'd3, 5'd0, 12'd77));
        emit(lw(5'd1, 5'd0, 12'h200));
        emit(alu_rr(7'h00, 3'b000, 5'd2, 5'd1, 5'd3));
        emit(sw(5'd2, 5'd0, 12'h120));
        expect_store(32'h120, fill_word(32'h200) + 32'd77);
        finish_test();

        // BEQ taken, BNE taken, then BEQ not taken
        start_test("branch_flush");
        emit(addi(5'd1, 5'd0, 12'd5));
        emit(addi(5'd2, 5'd0, 12'd5));
        emit(addi(5'd3, 5'd0, 12'd9));
        emit(addi(5'd4, 5'd0, 12'h7ad));
        emit(branch(3'b000, 5'd1, 5'd2, 13'd12));
        poison_pair();
        emit(branch(3'b001, 5'd1, 5'd3, 13'd12));
        poison_pair();
        emit(branch(3'b000, 5'd1, 5'd3, 13'd12));
        emit(sw(5'd1, 5'd0, 12'h130));
        emit(sw(5'd3, 5'd0, 12'h134));
        expect_store(32'h130, 32'd5);
        expect_store(32'h134, 32'd9);
        finish_test();

        start_test("jal_link");
        emit(addi(5'd4, 5'd0, 12'h7ad));
        link = start_pc + {22'd0, pc_w, 2'b00} + 32'd4;
        emit(jal(5'd5, 21'd12));
        poison_pair();
        emit(sw(5'd5, 5'd0, 12'h140));
        expect_store(32'h140, link);
        finish_test();

        start_test("random_addi");
        acc = 32'd0;
        emit(addi(5'd10, 5'd0, 12'd0));
        for (int k = 0; k < 20; k++) begin
            rng = lcg(rng);
            acc = acc + {{20{rng[27]}}, rng[27:16]};
            emit(addi(5'd10, 5'd10, rng[27:16]));
        end
        emit(sw(5'd10, 5'd0, 12'h150));
        expect_store(32'h150, acc);
        finish_test();

        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
hdl/core_pkg.sv
hdl/pipe_stage_if.sv
hdl/pipe_reg.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/memory_stage.sv
hdl/rv_core_top.sv
verification/rv_core_checker.sv
verification/rv_core_tb.sv

// ==== Makefile ====
.PHONY: all lint clean

all: obj_dir/Vrv_core_tb
	./obj_dir/Vrv_core_tb > sim.log 2>&1; cat sim.log
	@if grep -q "Simulation failed" sim.log; then exit 1; fi
	@grep -q "Simulation completed successfully" sim.log

obj_dir/Vrv_core_tb: verilog.f hdl/*.sv verification/*.sv
	verilator --binary --timing --assert --top-module rv_core_tb -f verilog.f

lint:
	verilator --lint-only -Wall --timing --assert --top-module rv_core_tb -f verilog.f

clean:
	rm -rf obj_dir sim.log
